// File: common/tile_config.svh
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Message field widths
`define ADDR_WIDTH 16
`define DATA_WIDTH 32
`define TAG_WIDTH  4

// Everything below DRAM_BASE is local
`define DRAM_BASE 16'h8000

// Local device field sits at addr[DEV_LSB +: 3]
`define DEV_LSB 12

// Local device codes
`define CFG_DEV   3'd1
`define CACHE_DEV 3'd2

// Config registers are indexed by the low address bits
`define CFG_REGS 8

`endif

// File: common/tile_pkg.sv
`default_nettype none

`include "tile_config.svh"

package tile_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;
  typedef logic [`TAG_WIDTH-1:0]  tag_t;
  typedef logic [2:0]             dev_t;

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // Header is echoed unchanged in every response
  typedef struct packed
  {
    mem_op_e op;
    addr_t   addr;
    tag_t    tag;
  } mem_hdr_s;

  // Shared by commands and responses
  typedef struct packed
  {
    mem_hdr_s hdr;
    data_t    data;
  } mem_msg_s;

  typedef enum logic [1:0]
  {
    tgt_mem  = 2'd0,
    tgt_cfg  = 2'd1,
    tgt_loop = 2'd2
  } target_e;

endpackage

`default_nettype wire

// File: hdl/mem_cmd_dispatch.sv
`default_nettype none

`include "tile_config.svh"

module mem_cmd_dispatch
  (input  wire tile_pkg::mem_msg_s cmd_i
   , input  wire logic             cmd_v_i
   , output logic                  cmd_ready_o

   , output tile_pkg::mem_msg_s    tgt_msg_o
   , output logic                  mem_v_o
   , output logic                  cfg_v_o
   , output logic                  loop_v_o

   , input  wire logic             mem_ready_i
   , input  wire logic             cfg_ready_i
   , input  wire logic             loop_ready_i
   );

  import tile_pkg::*;

  dev_t    dev;
  target_e tgt;
  logic    cmd_go;

  assign dev = cmd_i.hdr.addr[`DEV_LSB +: 3];

  // Cache device traffic leaves through the memory port as well
  always_comb
  begin
    if (cmd_i.hdr.addr >= `DRAM_BASE)
      tgt = tgt_mem;
    else if (dev == `CACHE_DEV)
      tgt = tgt_mem;
    else if (dev == `CFG_DEV)
      tgt = tgt_cfg;
    else
      tgt = tgt_loop;
  end

  // Accept only when every target can take a command
  assign cmd_ready_o = mem_ready_i & cfg_ready_i & loop_ready_i;
  assign cmd_go      = cmd_v_i & cmd_ready_o;

  assign tgt_msg_o = cmd_i;
  assign mem_v_o   = cmd_go & (tgt == tgt_mem);
  assign cfg_v_o   = cmd_go & (tgt == tgt_cfg);
  assign loop_v_o  = cmd_go & (tgt == tgt_loop);

endmodule

`default_nettype wire

// File: hdl/cfg_regs.sv
`default_nettype none

`include "tile_config.svh"

module cfg_regs
  (input  wire logic               clk_i
   , input  wire logic             arst_n_i

   , input  wire tile_pkg::mem_msg_s cmd_i
   , input  wire logic             cmd_v_i
   , output logic                  cmd_ready_o

   , output tile_pkg::mem_msg_s    resp_o
   , output logic                  resp_v_o
   , input  wire logic             resp_yumi_i
   );

  import tile_pkg::*;

  localparam int IDX_W = $clog2(`CFG_REGS);

  data_t            regs_q [`CFG_REGS];
  mem_msg_s         resp_q;
  logic             resp_v_q;
  logic             cmd_fire;
  logic             is_write;
  logic [IDX_W-1:0] idx;

  // One response in flight at a time
  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.hdr.op == op_write);
  assign idx         = cmd_i.hdr.addr[IDX_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < `CFG_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (cmd_fire && is_write)
    begin
      regs_q[idx] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (cmd_fire)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  // Writes answer with the new word
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_q.hdr  <= cmd_i.hdr;
      resp_q.data <= is_write ? cmd_i.data : regs_q[idx];
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i) resp_yumi_i |-> resp_v_o)
    else $error("cfg_regs: yumi without a pending response");

endmodule

`default_nettype wire

// File: hdl/loopback_dev.sv
`default_nettype none

module loopback_dev
  (input  wire logic               clk_i
   , input  wire logic             arst_n_i

   , input  wire tile_pkg::mem_msg_s cmd_i
   , input  wire logic             cmd_v_i
   , output logic                  cmd_ready_o

   , output tile_pkg::mem_msg_s    resp_o
   , output logic                  resp_v_o
   , input  wire logic             resp_yumi_i
   );

  import tile_pkg::*;

  mem_hdr_s hdr_q;
  logic     resp_v_q;
  logic     cmd_fire;

  assign cmd_ready_o = ~resp_v_q;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (cmd_fire)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      hdr_q <= cmd_i.hdr;
  end

  // Unmapped space reads as zero, writes are dropped
  assign resp_o   = '{hdr: hdr_q, data: '0};
  assign resp_v_o = resp_v_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i) resp_yumi_i |-> resp_v_o)
    else $error("loopback_dev: yumi without a pending response");

endmodule

`default_nettype wire

// File: hdl/mem_resp_arbiter.sv
`default_nettype none

module mem_resp_arbiter
  (input  wire logic               clk_i
   , input  wire logic             arst_n_i

   , input  wire tile_pkg::mem_msg_s mem_resp_i
   , input  wire tile_pkg::mem_msg_s cfg_resp_i
   , input  wire tile_pkg::mem_msg_s loop_resp_i
   , input  wire logic             mem_v_i
   , input  wire logic             cfg_v_i
   , input  wire logic             loop_v_i
   , output logic                  mem_yumi_o
   , output logic                  cfg_yumi_o
   , output logic                  loop_yumi_o

   , output tile_pkg::mem_msg_s    resp_o
   , output logic                  resp_v_o
   , input  wire logic             resp_ready_i
   );

  import tile_pkg::*;

  localparam int MSG_W = $bits(mem_msg_s);

  mem_msg_s   fifo_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       full;
  logic       push;
  logic       pop;
  logic [2:0] req;
  logic [2:0] gnt;
  mem_msg_s   sel_msg;

  assign full = (count_q == 2'd2);
  assign req  = {loop_v_i, cfg_v_i, mem_v_i};

  // Memory first, then cfg, then loopback
  always_comb
  begin
    gnt = 3'b000;
    if (!full)
    begin
      if (req[0])
        gnt = 3'b001;
      else if (req[1])
        gnt = 3'b010;
      else if (req[2])
        gnt = 3'b100;
    end
  end

  assign {loop_yumi_o, cfg_yumi_o, mem_yumi_o} = gnt;

  assign sel_msg = mem_msg_s'(({MSG_W{gnt[0]}} & mem_resp_i)
                            | ({MSG_W{gnt[1]}} & cfg_resp_i)
                            | ({MSG_W{gnt[2]}} & loop_resp_i));

  assign push = |gnt;
  assign pop  = resp_v_o & resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop)
        count_q <= count_q + 2'd1;
      else if (pop && !push)
        count_q <= count_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      fifo_q[wr_ptr_q] <= sel_msg;
  end

  assign resp_o   = fifo_q[rd_ptr_q];
  assign resp_v_o = (count_q != 2'd0);

  // External memory keeps its response until granted
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (mem_v_i && !mem_yumi_o) |=> (mem_v_i && $stable(mem_resp_i)))
    else $error("mem_resp_arbiter: memory response changed before its grant");

endmodule

`default_nettype wire

// File: hdl/mem_tile.sv
`default_nettype none

module mem_tile
  (input  wire logic               clk_i
   , input  wire logic             arst_n_i

   , input  wire tile_pkg::mem_msg_s cmd_i
   , input  wire logic             cmd_v_i
   , output logic                  cmd_ready_o

   , output tile_pkg::mem_msg_s    resp_o
   , output logic                  resp_v_o
   , input  wire logic             resp_ready_i

   , output tile_pkg::mem_msg_s    mem_cmd_o
   , output logic                  mem_cmd_v_o
   , input  wire logic             mem_cmd_ready_i

   , input  wire tile_pkg::mem_msg_s mem_resp_i
   , input  wire logic             mem_resp_v_i
   , output logic                  mem_resp_ready_o
   );

  import tile_pkg::*;

  mem_msg_s tgt_msg;
  logic     cfg_cmd_v;
  logic     cfg_cmd_ready;
  logic     loop_cmd_v;
  logic     loop_cmd_ready;

  mem_msg_s cfg_resp;
  logic     cfg_resp_v;
  logic     cfg_resp_yumi;
  mem_msg_s loop_resp;
  logic     loop_resp_v;
  logic     loop_resp_yumi;

  // Memory target is the external port itself
  assign mem_cmd_o = tgt_msg;

  mem_cmd_dispatch dispatch_inst
    (.cmd_i(cmd_i)
     , .cmd_v_i(cmd_v_i)
     , .cmd_ready_o(cmd_ready_o)
     , .tgt_msg_o(tgt_msg)
     , .mem_v_o(mem_cmd_v_o)
     , .cfg_v_o(cfg_cmd_v)
     , .loop_v_o(loop_cmd_v)
     , .mem_ready_i(mem_cmd_ready_i)
     , .cfg_ready_i(cfg_cmd_ready)
     , .loop_ready_i(loop_cmd_ready)
     );

  cfg_regs cfg_inst
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .cmd_i(tgt_msg)
     , .cmd_v_i(cfg_cmd_v)
     , .cmd_ready_o(cfg_cmd_ready)
     , .resp_o(cfg_resp)
     , .resp_v_o(cfg_resp_v)
     , .resp_yumi_i(cfg_resp_yumi)
     );

  loopback_dev loop_inst
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .cmd_i(tgt_msg)
     , .cmd_v_i(loop_cmd_v)
     , .cmd_ready_o(loop_cmd_ready)
     , .resp_o(loop_resp)
     , .resp_v_o(loop_resp_v)
     , .resp_yumi_i(loop_resp_yumi)
     );

  mem_resp_arbiter arb_inst
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .mem_resp_i(mem_resp_i)
     , .cfg_resp_i(cfg_resp)
     , .loop_resp_i(loop_resp)
     , .mem_v_i(mem_resp_v_i)
     , .cfg_v_i(cfg_resp_v)
     , .loop_v_i(loop_resp_v)
     , .mem_yumi_o(mem_resp_ready_o)
     , .cfg_yumi_o(cfg_resp_yumi)
     , .loop_yumi_o(loop_resp_yumi)
     , .resp_o(resp_o)
     , .resp_v_o(resp_v_o)
     , .resp_ready_i(resp_ready_i)
     );

endmodule

`default_nettype wire

// File: verification/tb_mem_tile.sv
`default_nettype none

`include "tile_config.svh"

module tb_mem_tile;

  timeunit 1ns;
  timeprecision 1ps;

  import tile_pkg::*;

  localparam int NUM_TAGS       = 1 << `TAG_WIDTH;
  localparam int RANDOM_CMDS    = 200;
  localparam int TIMEOUT_CYCLES = 4000;

  logic     clk_i;
  logic     arst_n_i;
  mem_msg_s cmd_i;
  logic     cmd_v_i;
  logic     cmd_ready_o;
  mem_msg_s resp_o;
  logic     resp_v_o;
  logic     resp_ready_i;
  mem_msg_s mem_cmd_o;
  logic     mem_cmd_v_o;
  logic     mem_cmd_ready_i;
  mem_msg_s mem_resp_i;
  logic     mem_resp_v_i;
  logic     mem_resp_ready_o;

  logic [31:0] lfsr_q;
  mem_msg_s    cmds [$];
  mem_msg_s    mem_q [$];
  mem_msg_s    issued [NUM_TAGS];
  mem_msg_s    expected [NUM_TAGS];
  bit          busy [NUM_TAGS];
  data_t       cfg_model [`CFG_REGS];
  int          busy_count;
  int          cmd_idx;
  int          cycle_cnt = 0;
  tag_t        next_tag;
  bit          cmd_accepted;
  bit          mem_resp_done;
  bit          mem_delay_armed;
  logic [1:0]  mem_delay;

  mem_tile mem_tile_inst
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .cmd_i(cmd_i)
     , .cmd_v_i(cmd_v_i)
     , .cmd_ready_o(cmd_ready_o)
     , .resp_o(resp_o)
     , .resp_v_o(resp_v_o)
     , .resp_ready_i(resp_ready_i)
     , .mem_cmd_o(mem_cmd_o)
     , .mem_cmd_v_o(mem_cmd_v_o)
     , .mem_cmd_ready_i(mem_cmd_ready_i)
     , .mem_resp_i(mem_resp_i)
     , .mem_resp_v_i(mem_resp_v_i)
     , .mem_resp_ready_o(mem_resp_ready_o)
     );

  always
  begin
    #50;
    clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Checks failed");
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_error(input string msg);
    $display("Checks failed");
    $display("FAIL at %0d ns: %s", $time, msg);
    $fatal(1, "stopping at the first error");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_next_bit()};
    return v;
  endfunction

  function automatic logic is_mem_addr(input addr_t addr);
    return (addr >= `DRAM_BASE) || (addr[`DEV_LSB +: 3] == `CACHE_DEV);
  endfunction

  // Memory model reply data
  function automatic data_t memory_data(input mem_msg_s cmd);
    return (cmd.hdr.op == op_write) ? cmd.data : data_t'(cmd.hdr.addr);
  endfunction

  function automatic mem_msg_s predict_response(input mem_msg_s cmd);
    mem_msg_s   r;
    logic [2:0] idx;
    r.hdr = cmd.hdr;
    idx = cmd.hdr.addr[2:0];
    if (is_mem_addr(cmd.hdr.addr))
      r.data = memory_data(cmd);
    else if (cmd.hdr.addr[`DEV_LSB +: 3] == `CFG_DEV)
    begin
      if (cmd.hdr.op == op_write)
        cfg_model[idx] = cmd.data;
      r.data = cfg_model[idx];
    end
    else
      r.data = '0;
    return r;
  endfunction

  function automatic addr_t local_addr(input dev_t dev, input logic [2:0] idx);
    addr_t a;
    a = addr_t'(rand_bits(16)) & addr_t'(`DRAM_BASE - 1);
    a[`DEV_LSB +: 3] = dev;
    a[2:0] = idx;
    return a;
  endfunction

  task automatic add_cmd(input mem_op_e op, input addr_t addr, input data_t data);
    mem_msg_s m;
    m.hdr.op   = op;
    m.hdr.addr = addr;
    m.hdr.tag  = '0;
    m.data     = data;
    cmds.push_back(m);
  endtask

  task automatic build_commands();
    dev_t loop_devs [6];
    loop_devs = '{3'd0, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 4; i++)
      add_cmd(op_write, local_addr(`CFG_DEV, 3'(i)), rand_bits(32));
    // Second write to index 0 must win
    add_cmd(op_write, local_addr(`CFG_DEV, 3'd0), rand_bits(32));
    for (int i = 0; i < `CFG_REGS; i++)
      add_cmd(op_read, local_addr(`CFG_DEV, 3'(i)), rand_bits(32));
    foreach (loop_devs[i])
      add_cmd(mem_op_e'(rand_bits(1)), local_addr(loop_devs[i], 3'(i)), rand_bits(32));
    add_cmd(op_write, addr_t'(rand_bits(16)) | `DRAM_BASE, rand_bits(32));
    add_cmd(op_read, addr_t'(rand_bits(16)) | `DRAM_BASE, rand_bits(32));
    add_cmd(op_write, local_addr(`CACHE_DEV, 3'd5), rand_bits(32));
    add_cmd(op_read, local_addr(`CACHE_DEV, 3'd2), rand_bits(32));
    for (int i = 0; i < RANDOM_CMDS; i++)
      add_cmd(mem_op_e'(rand_bits(1)), addr_t'(rand_bits(16)), rand_bits(32));
  endtask

  task automatic drive_inputs();
    mem_msg_s m;
    resp_ready_i    = (rand_bits(2) != 0);
    mem_cmd_ready_i = (rand_bits(2) != 0);
    if (mem_resp_done)
    begin
      mem_resp_v_i = 1'b0;
      void'(mem_q.pop_front());
      mem_resp_done   = 1'b0;
      mem_delay_armed = 1'b0;
    end
    if (!mem_resp_v_i && mem_q.size() > 0)
    begin
      if (!mem_delay_armed)
      begin
        mem_delay       = 2'(rand_bits(2));
        mem_delay_armed = 1'b1;
      end
      if (mem_delay == 2'd0)
      begin
        mem_resp_i.hdr  = mem_q[0].hdr;
        mem_resp_i.data = memory_data(mem_q[0]);
        mem_resp_v_i    = 1'b1;
      end
      else
        mem_delay = mem_delay - 2'd1;
    end
    if (cmd_accepted)
    begin
      cmd_v_i      = 1'b0;
      cmd_accepted = 1'b0;
    end
    // A tag is not reused until its response is back
    if (!cmd_v_i && cmd_idx < cmds.size() && !busy[next_tag])
    begin
      m = cmds[cmd_idx];
      m.hdr.tag = next_tag;
      issued[next_tag]   = m;
      expected[next_tag] = predict_response(m);
      busy[next_tag]     = 1'b1;
      busy_count = busy_count + 1;
      next_tag   = next_tag + 1'b1;
      cmd_idx    = cmd_idx + 1;
      cmd_i      = m;
      cmd_v_i    = 1'b1;
    end
  endtask

  task automatic sample_outputs();
    tag_t t;
    if (mem_cmd_v_o)
      assert (is_mem_addr(mem_cmd_o.hdr.addr))
        else report_error($sformatf("address %h on mem_cmd_o", mem_cmd_o.hdr.addr));
    if (!mem_cmd_ready_i)
      assert (!cmd_ready_o)
        else report_error("cmd_ready_o high while mem_cmd_ready_i is low");
    if (cmd_v_i && cmd_ready_o)
    begin
      cmd_accepted = 1'b1;
      assert (mem_cmd_v_o == is_mem_addr(cmd_i.hdr.addr))
        else report_error("mem_cmd_v_o does not follow the address decode");
    end
    if (mem_cmd_v_o && mem_cmd_ready_i)
    begin
      t = mem_cmd_o.hdr.tag;
      assert (busy[t] && mem_cmd_o == issued[t])
        else report_error($sformatf("mem_cmd_o %h differs from the issued command", mem_cmd_o));
      mem_q.push_back(mem_cmd_o);
    end
    if (mem_resp_ready_o)
      assert (mem_resp_v_i)
        else report_error("mem_resp_ready_o high without a memory response");
    // Memory has top priority, so an empty FIFO must take its response
    if (mem_resp_v_i && !resp_v_o)
      assert (mem_resp_ready_o)
        else report_error("memory response not granted while the FIFO is empty");
    if (mem_resp_v_i && mem_resp_ready_o)
      mem_resp_done = 1'b1;
    if (resp_v_o && resp_ready_i)
    begin
      t = resp_o.hdr.tag;
      assert (busy[t])
        else report_error($sformatf("response for tag %0d that is not outstanding", t));
      assert (resp_o == expected[t])
        else report_error($sformatf("tag %0d: resp_o %h, expected %h", t, resp_o, expected[t]));
      busy[t]    = 1'b0;
      busy_count = busy_count - 1;
    end
  endtask

  // Held output while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (resp_v_o && !resp_ready_i) |=> (resp_v_o && $stable(resp_o)))
    else report_error("resp_o changed while resp_ready_i was low");

  initial
  begin
    clk_i           = 1'b0;
    arst_n_i        = 1'b0;
    cmd_i           = '0;
    cmd_v_i         = 1'b0;
    resp_ready_i    = 1'b0;
    mem_cmd_ready_i = 1'b0;
    mem_resp_i      = '0;
    mem_resp_v_i    = 1'b0;
    lfsr_q          = 32'hc85b612c;
    busy_count      = 0;
    cmd_idx         = 0;
    next_tag        = '0;
    cmd_accepted    = 1'b0;
    mem_resp_done   = 1'b0;
    mem_delay_armed = 1'b0;
    mem_delay       = 2'd0;
    foreach (busy[i])
      busy[i] = 1'b0;
    foreach (cfg_model[i])
      cfg_model[i] = '0;
    build_commands();

    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(posedge clk_i);
    assert (!resp_v_o && !mem_cmd_v_o)
      else report_error("resp_v_o or mem_cmd_v_o high after reset");

    while (cmd_idx < cmds.size() || cmd_v_i || busy_count != 0)
    begin
      @(negedge clk_i);
      drive_inputs();
      @(posedge clk_i);
      sample_outputs();
    end

    if (busy_count == 0 && mem_q.size() == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
      report_error("responses still outstanding at the end of the run");
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/tile_pkg.sv
hdl/mem_cmd_dispatch.sv
hdl/cfg_regs.sv
hdl/loopback_dev.sv
hdl/mem_resp_arbiter.sv
hdl/mem_tile.sv
verification/tb_mem_tile.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -sv --assert --timescale 1ns/1ps \
  -f compile.f \
  --top-module tb_mem_tile \
  -o tb_mem_tile

./obj_dir/tb_mem_tile
